// ==== alu_imm_unit.f ====
+incdir+src
src/core_types_pkg.sv
src/q_fast_ready.sv
src/alu.sv
src/alu_imm_pipeline.sv
src/prf_banked.sv
src/alu_imm_unit.sv
bench/alu_imm_unit_sva.sv
bench/alu_imm_unit_tb.sv

// ==== bench/alu_imm_unit_sva.sv ====
// handshake and FIFO assertions for the ALU immediate unit, bound into its top level
`default_nettype none

module alu_imm_unit_sva
    import core_types_pkg::*;
(
    input logic      CLK,
    input logic      nRST,
    input logic      issue_valid,
    input logic      issue_ready,
    input logic      oc_enq_fire,
    input oc_entry_t oc_enq_entry,
    input logic      reg_read_resp_valid,
    input logic      WB_valid,
    input logic      WB_ready,
    input wb_t       wb,
    input logic      rr_enq_valid,
    input logic      rr_enq_ready,
    input logic      rr_deq_ready,
    input logic      fwd_enq_valid,
    input logic      fwd_enq_ready,
    input logic      fwd_deq_ready
);
    // ------------------------------------------------------------
    // writeback and issue handshakes

    wb_hold_a: assert property (@(posedge CLK) disable iff (!nRST)
        (WB_valid && !WB_ready) |=> (WB_valid && $stable(wb)))
        else $error("wb changed while stalled");

    issue_gate_a: assert property (@(posedge CLK) disable iff (!nRST)
        oc_enq_fire == (issue_valid && issue_ready))
        else $error("buffer entry does not match the issue handshake");

    // one-cycle register read response for each buffered register-source op
    read_resp_a: assert property (@(posedge CLK) disable iff (!nRST)
        (oc_enq_fire && oc_enq_entry.A_is_reg) |=> reg_read_resp_valid)
        else $error("register read without a response one cycle later");

    read_resp_origin_a: assert property (@(posedge CLK) disable iff (!nRST)
        reg_read_resp_valid |-> $past(oc_enq_fire && oc_enq_entry.A_is_reg))
        else $error("register read response without a register-source issue");

    // ------------------------------------------------------------
    // operand FIFOs

    rr_no_overflow_a: assert property (@(posedge CLK) disable iff (!nRST)
        rr_enq_valid |-> (rr_enq_ready || rr_deq_ready))
        else $error("register operand FIFO overflow");

    fwd_no_overflow_a: assert property (@(posedge CLK) disable iff (!nRST)
        fwd_enq_valid |-> (fwd_enq_ready || fwd_deq_ready))
        else $error("forward operand FIFO overflow");

endmodule

`default_nettype wire

// ==== bench/alu_imm_unit_tb.sv ====
// testbench for the ALU immediate unit with a shadow register file and reference ALU
`include "core_config.svh"
`default_nettype none

module alu_imm_unit_tb
    import core_types_pkg::*;
();
    // about 1,200 cycles of tests, back-pressure phase the longest
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int BANK_W = `LOG_PRF_BANK_COUNT;

    logic       CLK;
    logic       nRST;
    logic       issue_valid;
    issue_t     issue;
    logic       issue_ready;
    logic       ext_write_valid;
    prf_write_t ext_write;
    logic       WB_valid;
    wb_t        wb;
    logic       WB_ready = 1'b1;

    integer seed = 32'hf09ccac3;
    // separate stream for WB_ready
    integer ready_seed = ~32'hf09ccac3;
    word_t  ready_rnd;
    logic   random_ready;

    word_t    shadow_regs [`PR_COUNT];
    word_t    shadow_bank [`PRF_BANK_COUNT];
    wb_t      expected_q [$];
    wb_t      exp_wb;
    rob_idx_t rob_next;
    string    test_name;
    logic     saw_not_ready;
    int       cycle_count = 0;
    int       i;
    int       k;
    issue_t   op;
    word_t    rnd;
    pr_idx_t  pr;
    logic [BANK_W-1:0] bank;

    alu_op_t op_list [9] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
                             ALU_SRL, ALU_SRA, ALU_OR, ALU_AND};

    alu_imm_unit alu_imm_unit_i (
        .CLK(CLK), .nRST(nRST),
        .issue_valid(issue_valid), .issue(issue), .issue_ready(issue_ready),
        .ext_write_valid(ext_write_valid), .ext_write(ext_write),
        .WB_valid(WB_valid), .wb(wb), .WB_ready(WB_ready)
    );

    bind alu_imm_unit alu_imm_unit_sva alu_imm_unit_sva_i (
        .CLK(CLK), .nRST(nRST),
        .issue_valid(issue_valid), .issue_ready(issue_ready),
        .oc_enq_fire(alu_imm_pipeline_i.is_oc_buffer.enq_fire),
        .oc_enq_entry(alu_imm_pipeline_i.issue_entry),
        .reg_read_resp_valid(reg_read_resp_valid),
        .WB_valid(WB_valid), .WB_ready(WB_ready), .wb(wb),
        .rr_enq_valid(alu_imm_pipeline_i.a_reg_buffer.enq_valid),
        .rr_enq_ready(alu_imm_pipeline_i.a_reg_buffer.enq_ready),
        .rr_deq_ready(alu_imm_pipeline_i.a_reg_buffer.deq_ready),
        .fwd_enq_valid(alu_imm_pipeline_i.a_fwd_buffer.enq_valid),
        .fwd_enq_ready(alu_imm_pipeline_i.a_fwd_buffer.enq_ready),
        .fwd_deq_ready(alu_imm_pipeline_i.a_fwd_buffer.deq_ready)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // ------------------------------------------------------------
    // reference model

    function automatic word_t alu_ref(input alu_op_t fn, input word_t a, input logic [11:0] imm);
        word_t      b;
        logic [4:0] sh;
        b  = {{20{imm[11]}}, imm};
        sh = b[4:0];
        case (fn)
            ALU_ADD:  return a + b;
            ALU_SLL:  return a << sh;
            // signed compare by flipping the sign bits
            ALU_SLT:  return ((a ^ 32'h80000000) < (b ^ 32'h80000000)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | ({32{a[31]}} & ~(32'hffffffff >> sh));
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return '0;
        endcase
    endfunction

    function automatic wb_t expected_for(input issue_t iop);
        word_t a;
        wb_t   res;
        if (iop.A_is_zero) begin
            a = '0;
        end else if (iop.A_forward) begin
            a = shadow_bank[iop.A_PR[BANK_W-1:0]];
        end else begin
            a = shadow_regs[iop.A_PR];
        end
        res.data      = alu_ref(iop.op, a, iop.imm12);
        res.PR        = iop.dest_PR;
        res.ROB_index = iop.ROB_index;
        return res;
    endfunction

    // register source in 1..31, destination in 32..63
    function automatic issue_t random_op();
        issue_t rop;
        word_t  r;
        int     idx;
        r = $random(seed);
        idx = r % 9;
        rop = '0;
        rop.op = op_list[idx];
        rop.imm12 = r[11:0];
        r = $random(seed);
        rop.A_PR = pr_idx_t'(r % 31 + 1);
        rop.dest_PR = {1'b1, r[20:16]};
        return rop;
    endfunction

    // ------------------------------------------------------------
    // failure reporting and compare tasks

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_wb(input string name, input wb_t exp, input wb_t act);
        string msg;
        if (act !== exp) begin
            msg = $sformatf("Error %s: expected data %h PR %0d ROB %0d", name,
                exp.data, exp.PR, exp.ROB_index);
            msg = {msg, $sformatf(", got data %h PR %0d ROB %0d",
                act.data, act.PR, act.ROB_index)};
            fail_run(msg);
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("Error %s: expected %b, got %b", name, exp, act));
        end
    endtask

    // ------------------------------------------------------------
    // drivers, all on the falling edge

    // valid held until a rising edge sees issue_ready
    task automatic issue_op(input issue_t iop);
        issue_t iop_r;
        @(negedge CLK);
        iop_r = iop;
        iop_r.ROB_index = rob_next;
        issue = iop_r;
        issue_valid = 1'b1;
        while (!issue_ready) begin
            saw_not_ready = 1'b1;
            @(negedge CLK);
        end
        rob_next = rob_next + 1'b1;
        expected_q.push_back(expected_for(iop_r));
        @(posedge CLK);
    endtask

    task automatic write_reg(input pr_idx_t wpr, input word_t data);
        @(negedge CLK);
        issue_valid = 1'b0;
        ext_write_valid = 1'b1;
        ext_write.PR = wpr;
        ext_write.data = data;
        @(negedge CLK);
        ext_write_valid = 1'b0;
    endtask

    task automatic drain();
        @(negedge CLK);
        issue_valid = 1'b0;
        while (expected_q.size() != 0) begin
            @(negedge CLK);
        end
    endtask

    always @(negedge CLK) begin
        if (random_ready) begin
            ready_rnd = $random(ready_seed);
            WB_ready = ready_rnd[0];
        end else begin
            WB_ready = 1'b1;
        end
    end

    // ------------------------------------------------------------
    // monitor: shadow state and writeback compare

    always @(posedge CLK) begin
        if (!nRST) begin
            for (k = 0; k < `PR_COUNT; k++) shadow_regs[k] = '0;
            for (k = 0; k < `PRF_BANK_COUNT; k++) shadow_bank[k] = '0;
        end else begin
            // external write first so a writeback overrides it
            if (ext_write_valid) begin
                if (ext_write.PR != '0) shadow_regs[ext_write.PR] = ext_write.data;
                shadow_bank[ext_write.PR[BANK_W-1:0]] = ext_write.data;
            end
            if (WB_valid && WB_ready) begin
                if (expected_q.size() == 0) begin
                    fail_run("writeback arrived with no operation pending");
                end else begin
                    exp_wb = expected_q.pop_front();
                    check_wb(test_name, exp_wb, wb);
                    if (exp_wb.PR != '0) shadow_regs[exp_wb.PR] = exp_wb.data;
                    shadow_bank[exp_wb.PR[BANK_W-1:0]] = exp_wb.data;
                end
            end
        end
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run("timeout, the tests did not finish within the cycle limit");
        end
    end

    // ------------------------------------------------------------
    // test sequence

    initial begin
        nRST = 1'b0;
        issue_valid = 1'b0;
        issue = '0;
        ext_write_valid = 1'b0;
        ext_write = '0;
        random_ready = 1'b0;
        saw_not_ready = 1'b0;
        rob_next = '0;
        test_name = "reset";
        repeat (10) @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);
        check_ready("reset issue_ready", 1'b1, issue_ready);
        check_ready("reset WB_valid", 1'b0, WB_valid);

        // source registers, both signs of A
        test_name = "preload";
        for (i = 1; i < 32; i++) begin
            rnd = $random(seed);
            rnd[31] = i[0];
            write_reg(pr_idx_t'(i), rnd);
        end

        test_name = "register source";
        repeat (300) issue_op(random_op());
        drain();

        test_name = "zero source";
        repeat (20) begin
            op = random_op();
            op.A_is_zero = 1'b1;
            issue_op(op);
        end
        drain();

        // bank value set by an external write or by a writeback
        test_name = "forward";
        for (i = 0; i < 16; i++) begin
            bank = i[BANK_W-1:0];
            op = random_op();
            if (i[2]) begin
                rnd = $random(seed);
                pr = op.dest_PR;
                pr[BANK_W-1:0] = bank;
                write_reg(pr, rnd);
            end else begin
                op.dest_PR[BANK_W-1:0] = bank;
                issue_op(op);
            end
            drain();
            op = random_op();
            op.A_forward = 1'b1;
            op.A_PR[BANK_W-1:0] = bank;
            issue_op(op);
            drain();
        end

        test_name = "back-pressure";
        saw_not_ready = 1'b0;
        random_ready = 1'b1;
        repeat (300) issue_op(random_op());
        drain();
        random_ready = 1'b0;
        if (!saw_not_ready) begin
            fail_run("issue_ready never dropped under back-pressure");
        end

        test_name = "register zero";
        op = random_op();
        op.op = ALU_ADD;
        op.A_is_zero = 1'b1;
        op.imm12 = 12'h123;
        op.dest_PR = '0;
        issue_op(op);
        drain();
        op.A_is_zero = 1'b0;
        op.A_PR = '0;
        op.imm12 = '0;
        op.dest_PR = 6'd40;
        issue_op(op);
        drain();

        // pipe must be empty and idle once every result is back
        @(negedge CLK);
        check_ready("idle WB_valid", 1'b0, WB_valid);
        check_ready("idle issue_ready", 1'b1, issue_ready);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module alu_imm_unit_tb -f alu_imm_unit.f \
    -o alu_imm_unit_sim > sim.log 2>&1 &&
    ./obj_dir/alu_imm_unit_sim >> sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1

// ==== src/alu.sv ====
// combinational integer ALU covering the RISC-V register-immediate operations
`default_nettype none

module alu
    import core_types_pkg::*;
(
    input  alu_op_t     op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] out
);
    logic [4:0] shamt;

    // only the low five bits matter for 32-bit shifts
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  out = a + b;
            ALU_SLL:  out = a << shamt;
            ALU_SLT:  out = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: out = {31'b0, a < b};
            ALU_XOR:  out = a ^ b;
            ALU_SRL:  out = a >> shamt;
            ALU_SRA:  out = $unsigned($signed(a) >>> shamt);
            ALU_OR:   out = a | b;
            ALU_AND:  out = a & b;
            default:  out = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/alu_imm_pipeline.sv ====
// register-immediate ALU pipe with issue buffer, operand collect and writeback stage
`include "core_config.svh"
`default_nettype none

module alu_imm_pipeline
    import core_types_pkg::*;
#(
    parameter int IS_OC_BUFFER_SIZE = `IS_OC_BUFFER_SIZE,
    parameter int PRF_RR_OUTPUT_BUFFER_SIZE = `PRF_RR_OUTPUT_BUFFER_SIZE
) (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       issue_valid,
    input  issue_t     issue,
    output logic       issue_ready,
    input  logic       A_reg_read_resp_valid,
    input  word_t      A_reg_read_resp_data,
    input  bank_data_t forward_data_by_bank,
    output logic       WB_valid,
    output wb_t        wb,
    input  logic       WB_ready
);
    logic stall_wb;

    oc_entry_t issue_entry;
    logic      oc_valid;
    oc_entry_t oc_entry;
    logic      oc_advance;
    logic      operands_ready;

    logic  rr_deq_valid;
    word_t rr_deq_data;
    logic  rr_deq_ready;

    logic                           fwd_capture_valid;
    logic [`LOG_PRF_BANK_COUNT-1:0] fwd_capture_bank;
    word_t                          fwd_capture_data;
    logic                           fwd_deq_valid;
    word_t                          fwd_deq_data;
    logic                           fwd_deq_ready;

    oc_entry_t wb_entry;
    word_t     wb_a;
    word_t     wb_b;
    word_t     alu_out;

    assign stall_wb = WB_valid & ~WB_ready;

    // ------------------------------------------------------------
    // issue to operand-collect buffer

    always_comb begin
        issue_entry.op        = issue.op;
        issue_entry.imm12     = issue.imm12;
        issue_entry.A_forward = issue.A_forward;
        issue_entry.A_is_reg  = ~(issue.A_forward | issue.A_is_zero);
        issue_entry.dest_PR   = issue.dest_PR;
        issue_entry.ROB_index = issue.ROB_index;
    end

    // only a valid/ready transfer enters, never a push into a full buffer
    q_fast_ready #(.T(oc_entry_t), .NUM_ENTRIES(IS_OC_BUFFER_SIZE)) is_oc_buffer (
        .CLK(CLK), .nRST(nRST),
        .enq_valid(issue_valid & issue_ready), .enq_data(issue_entry),
        .enq_ready(issue_ready),
        .deq_valid(oc_valid), .deq_data(oc_entry), .deq_ready(oc_advance)
    );

    // operand is either already queued or arriving this cycle
    assign operands_ready =
        (~oc_entry.A_is_reg | A_reg_read_resp_valid | rr_deq_valid) &
        (~oc_entry.A_forward | fwd_capture_valid | fwd_deq_valid);
    assign oc_advance = ~stall_wb & operands_ready;

    // ------------------------------------------------------------
    // operand FIFOs

    q_fast_ready #(.T(word_t), .NUM_ENTRIES(PRF_RR_OUTPUT_BUFFER_SIZE)) a_reg_buffer (
        .CLK(CLK), .nRST(nRST),
        .enq_valid(A_reg_read_resp_valid), .enq_data(A_reg_read_resp_data), .enq_ready(),
        .deq_valid(rr_deq_valid), .deq_data(rr_deq_data), .deq_ready(rr_deq_ready)
    );

    // forward bank value sampled one cycle after issue
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            fwd_capture_valid <= 1'b0;
        end else begin
            fwd_capture_valid <= issue_valid & issue_ready & issue.A_forward;
        end
    end

    always_ff @(posedge CLK) begin
        fwd_capture_bank <= issue.A_PR[`LOG_PRF_BANK_COUNT-1:0];
    end

    assign fwd_capture_data = forward_data_by_bank[fwd_capture_bank];

    q_fast_ready #(.T(word_t), .NUM_ENTRIES(PRF_RR_OUTPUT_BUFFER_SIZE)) a_fwd_buffer (
        .CLK(CLK), .nRST(nRST),
        .enq_valid(fwd_capture_valid), .enq_data(fwd_capture_data), .enq_ready(),
        .deq_valid(fwd_deq_valid), .deq_data(fwd_deq_data), .deq_ready(fwd_deq_ready)
    );

    // ------------------------------------------------------------
    // writeback stage

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            WB_valid <= 1'b0;
        end else if (!stall_wb) begin
            WB_valid <= oc_valid & operands_ready;
        end
    end

    // held while stalled
    always_ff @(posedge CLK) begin
        if (!stall_wb) begin
            wb_entry <= oc_entry;
        end
    end

    // operand FIFO heads stay put until the transfer pops them
    assign rr_deq_ready  = WB_valid & WB_ready & wb_entry.A_is_reg;
    assign fwd_deq_ready = WB_valid & WB_ready & wb_entry.A_forward;

    always_comb begin
        if (wb_entry.A_is_reg) begin
            wb_a = rr_deq_data;
        end else if (wb_entry.A_forward) begin
            wb_a = fwd_deq_data;
        end else begin
            wb_a = '0;
        end
        wb_b = {{20{wb_entry.imm12[11]}}, wb_entry.imm12};
    end

    alu alu_i (
        .op(wb_entry.op),
        .a(wb_a),
        .b(wb_b),
        .out(alu_out)
    );

    always_comb begin
        wb.data      = alu_out;
        wb.PR        = wb_entry.dest_PR;
        wb.ROB_index = wb_entry.ROB_index;
    end

endmodule

`default_nettype wire

// ==== src/alu_imm_unit.sv ====
// ALU immediate execution unit, the pipe joined to its banked register file
`default_nettype none

module alu_imm_unit
    import core_types_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    input  logic       issue_valid,
    input  issue_t     issue,
    output logic       issue_ready,
    input  logic       ext_write_valid,
    input  prf_write_t ext_write,
    output logic       WB_valid,
    output wb_t        wb,
    input  logic       WB_ready
);
    logic       read_req;
    logic       wb_fire;
    logic       reg_read_resp_valid;
    word_t      reg_read_resp_data;
    bank_data_t forward_data_by_bank;

    // read only for operations sourcing a register
    assign read_req = issue_valid & issue_ready & ~(issue.A_forward | issue.A_is_zero);
    assign wb_fire  = WB_valid & WB_ready;

    alu_imm_pipeline alu_imm_pipeline_i (
        .CLK(CLK), .nRST(nRST),
        .issue_valid(issue_valid), .issue(issue), .issue_ready(issue_ready),
        .A_reg_read_resp_valid(reg_read_resp_valid),
        .A_reg_read_resp_data(reg_read_resp_data),
        .forward_data_by_bank(forward_data_by_bank),
        .WB_valid(WB_valid), .wb(wb), .WB_ready(WB_ready)
    );

    prf_banked prf_banked_i (
        .CLK(CLK), .nRST(nRST),
        .read_valid(read_req), .read_PR(issue.A_PR),
        .read_resp_valid(reg_read_resp_valid), .read_resp_data(reg_read_resp_data),
        .wb_valid(wb_fire), .wb(wb),
        .ext_write_valid(ext_write_valid), .ext_write(ext_write),
        .forward_data_by_bank(forward_data_by_bank)
    );

endmodule

`default_nettype wire

// ==== src/core_config.svh ====
// core sizing constants for the ALU immediate execution pipe and its register file
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// physical register file
`define PR_COUNT 64
`define LOG_PR_COUNT $clog2(`PR_COUNT)

// banking by the low register bits
`define PRF_BANK_COUNT 4
`define LOG_PRF_BANK_COUNT $clog2(`PRF_BANK_COUNT)

// reorder buffer
`define ROB_ENTRIES 32
`define LOG_ROB_ENTRIES $clog2(`ROB_ENTRIES)

// default buffer depths
`define IS_OC_BUFFER_SIZE 2
`define PRF_RR_OUTPUT_BUFFER_SIZE 3

`endif

// ==== src/core_types_pkg.sv ====
// shared types for the integer core: ALU ops, issue, operand-collect and writeback payloads
`include "core_config.svh"
`default_nettype none

package core_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [`LOG_PR_COUNT-1:0] pr_idx_t;
    typedef logic [`LOG_ROB_ENTRIES-1:0] rob_idx_t;
    typedef logic [`PRF_BANK_COUNT-1:0][31:0] bank_data_t;

    // low three bits follow funct3, bit 3 picks the arithmetic shift
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SRA  = 4'b1101
    } alu_op_t;

    // ------------------------------------------------------------
    // pipeline payloads

    typedef struct packed {
        alu_op_t     op;
        logic [11:0] imm12;
        logic        A_forward;
        logic        A_is_zero;
        pr_idx_t     A_PR;
        pr_idx_t     dest_PR;
        rob_idx_t    ROB_index;
    } issue_t;

    typedef struct packed {
        alu_op_t     op;
        logic [11:0] imm12;
        logic        A_forward;
        logic        A_is_reg;
        pr_idx_t     dest_PR;
        rob_idx_t    ROB_index;
    } oc_entry_t;

    typedef struct packed {
        word_t    data;
        pr_idx_t  PR;
        rob_idx_t ROB_index;
    } wb_t;

    typedef struct packed {
        pr_idx_t PR;
        word_t   data;
    } prf_write_t;

endpackage

`default_nettype wire

// ==== src/prf_banked.sv ====
// banked physical register file with one read port, two write ports and bank forwards
`include "core_config.svh"
`default_nettype none

module prf_banked
    import core_types_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,
    input  logic       read_valid,
    input  pr_idx_t    read_PR,
    output logic       read_resp_valid,
    output word_t      read_resp_data,
    input  logic       wb_valid,
    input  wb_t        wb,
    input  logic       ext_write_valid,
    input  prf_write_t ext_write,
    output bank_data_t forward_data_by_bank
);
    word_t regs [`PR_COUNT];

    logic [`LOG_PRF_BANK_COUNT-1:0] wb_bank;
    logic [`LOG_PRF_BANK_COUNT-1:0] ext_bank;

    assign wb_bank  = wb.PR[`LOG_PRF_BANK_COUNT-1:0];
    assign ext_bank = ext_write.PR[`LOG_PRF_BANK_COUNT-1:0];

    // ------------------------------------------------------------
    // register array, writeback applied last so it wins a collision

    always_ff @(posedge CLK) begin
        if (ext_write_valid && ext_write.PR != '0) begin
            regs[ext_write.PR] <= ext_write.data;
        end
        if (wb_valid && wb.PR != '0) begin
            regs[wb.PR] <= wb.data;
        end
    end

    // ------------------------------------------------------------
    // read port, one cycle response

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            read_resp_valid <= 1'b0;
        end else begin
            read_resp_valid <= read_valid;
        end
    end

    // r0 is hardwired
    always_ff @(posedge CLK) begin
        read_resp_data <= (read_PR == '0) ? '0 : regs[read_PR];
    end

    // ------------------------------------------------------------
    // per-bank forward: last value written to the bank by either port

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            forward_data_by_bank <= '0;
        end else begin
            if (ext_write_valid) begin
                forward_data_by_bank[ext_bank] <= ext_write.data;
            end
            if (wb_valid) begin
                forward_data_by_bank[wb_bank] <= wb.data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/q_fast_ready.sv ====
// small circular FIFO for any payload type, ready taken from occupancy alone
`default_nettype none

module q_fast_ready #(
    parameter type T = logic [31:0],
    parameter int NUM_ENTRIES = 2
) (
    input  logic CLK,
    input  logic nRST,
    input  logic enq_valid,
    input  T     enq_data,
    output logic enq_ready,
    output logic deq_valid,
    output T     deq_data,
    input  logic deq_ready
);
    localparam int PTR_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;
    localparam int CNT_W = $clog2(NUM_ENTRIES + 1);

    T entries [NUM_ENTRIES];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic enq_fire;
    logic deq_fire;

    // wrap at the last entry, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        ptr_next = (ptr == PTR_W'(NUM_ENTRIES - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign enq_ready = (count != CNT_W'(NUM_ENTRIES));
    assign deq_valid = (count != '0);
    assign deq_data  = entries[head];
    assign deq_fire  = deq_valid & deq_ready;
    // full queue still takes a push when the head leaves this cycle
    assign enq_fire  = enq_valid & (enq_ready | deq_fire);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (enq_fire) begin
                tail <= ptr_next(tail);
            end
            if (deq_fire) begin
                head <= ptr_next(head);
            end
            if (enq_fire && !deq_fire) begin
                count <= count + 1'b1;
            end else if (deq_fire && !enq_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            entries[tail] <= enq_data;
        end
    end

endmodule

`default_nettype wire
